// File: verilog/trap_settings.svh
// shared widths, opcode codes, CSR addresses and cause values
// queue depth must be a power of two, at least 2
`ifndef TRAP_SETTINGS_SVH
`define TRAP_SETTINGS_SVH

// data and pc width
`define TRAP_XLEN 64

// pending event slots in front of the sequencer
`define TRAP_QUEUE_DEPTH 4

// decoded opcodes, anything else is a timer interrupt
`define TRAP_OP_ECALL 8'h01
`define TRAP_OP_MRET  8'h02

// machine csr addresses
`define CSR_ADDR_MSTATUS 12'h300
`define CSR_ADDR_MTVEC   12'h305
`define CSR_ADDR_MEPC    12'h341
`define CSR_ADDR_MCAUSE  12'h342

// mcause values
`define TRAP_CAUSE_ECALL `TRAP_XLEN'(11)
`define TRAP_CAUSE_TIMER {1'b1, {(`TRAP_XLEN - 4){1'b0}}, 3'd7}

`endif

// File: verilog/csr_pkg.sv
// csr address and data types for the four machine csrs
`include "trap_settings.svh"

package csr_pkg;

  typedef logic [11:0]            csr_addr_t;
  typedef logic [`TRAP_XLEN-1:0]  csr_data_t;

  // typed views of the addresses, for decoders
  localparam csr_addr_t ADDR_MSTATUS = `CSR_ADDR_MSTATUS;
  localparam csr_addr_t ADDR_MTVEC   = `CSR_ADDR_MTVEC;
  localparam csr_addr_t ADDR_MEPC    = `CSR_ADDR_MEPC;
  localparam csr_addr_t ADDR_MCAUSE  = `CSR_ADDR_MCAUSE;

endpackage

// File: verilog/trap_pkg.sv
// trap event fields and sequencer states
`include "trap_settings.svh"

package trap_pkg;

  typedef logic [7:0]             opcode_t;
  typedef logic [`TRAP_XLEN-1:0]  pc_t;

  typedef enum logic [3:0] {
    IDLE,
    ENTER_WR_MEPC, ENTER_WR_MCAUSE, ENTER_RD_MTVEC,
    ENTER_RD_MSTATUS, ENTER_WR_MSTATUS,
    LEAVE_RD_MSTATUS, LEAVE_RD_MEPC, LEAVE_WR_MSTATUS,
    REDIRECT
  } trap_state_e;

endpackage

// File: verilog/trap_event_queue.sv
// circular buffer of pending trap events, DEPTH must be a power of two
// head entry is shown as soon as it is stored, push and pop may share a cycle
`timescale 1ns/1ps
`include "trap_settings.svh"

module trap_event_queue #(
  parameter int DEPTH = `TRAP_QUEUE_DEPTH
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_valid,
  input  trap_pkg::opcode_t i_opcode,
  input  trap_pkg::pc_t     i_pc,
  input  logic              i_pop,
  output logic              o_ready,
  output logic              o_valid,
  output trap_pkg::opcode_t o_opcode,
  output trap_pkg::pc_t     o_pc
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  trap_pkg::opcode_t opcode_mem [DEPTH];
  trap_pkg::pc_t     pc_mem     [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign o_ready  = (count != CNT_W'(DEPTH));
  assign o_valid  = (count != '0);
  assign push     = i_valid && o_ready;
  assign pop      = i_pop && o_valid;    // stray pops on empty are ignored
  assign o_opcode = opcode_mem[rd_ptr];
  assign o_pc     = pc_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      opcode_mem[wr_ptr] <= i_opcode;
      pc_mem[wr_ptr]     <= i_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is 2**n
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: verilog/csr_file.sv
// mepc, mcause, mtvec and mstatus with a sequencer port and a host port
// unknown addresses read zero, a sequencer write drops any host write that cycle
`timescale 1ns/1ps

module csr_file (
  input  logic               clk,
  input  logic               rst,
  input  csr_pkg::csr_addr_t i_addr,
  input  logic               i_ren,
  input  logic               i_wen,
  input  csr_pkg::csr_data_t i_wdata,
  output csr_pkg::csr_data_t o_rdata,
  input  logic               i_host_wen,
  input  csr_pkg::csr_addr_t i_host_addr,
  input  csr_pkg::csr_data_t i_host_wdata,
  input  csr_pkg::csr_addr_t i_host_raddr,
  output csr_pkg::csr_data_t o_host_rdata
);

  csr_pkg::csr_data_t mepc;
  csr_pkg::csr_data_t mcause;
  csr_pkg::csr_data_t mtvec;
  csr_pkg::csr_data_t mstatus;

  logic               wen;
  csr_pkg::csr_addr_t waddr;
  csr_pkg::csr_data_t wdata;

  function automatic csr_pkg::csr_data_t read_csr(input csr_pkg::csr_addr_t addr);
    case (addr)
      csr_pkg::ADDR_MEPC:    return mepc;
      csr_pkg::ADDR_MCAUSE:  return mcause;
      csr_pkg::ADDR_MTVEC:   return mtvec;
      csr_pkg::ADDR_MSTATUS: return mstatus;
      default:               return '0;
    endcase
  endfunction

  // sequencer has write priority
  assign wen   = i_wen || i_host_wen;
  assign waddr = i_wen ? i_addr : i_host_addr;
  assign wdata = i_wen ? i_wdata : i_host_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      mepc    <= '0;
      mcause  <= '0;
      mtvec   <= '0;
      mstatus <= '0;
    end else if (wen) begin
      case (waddr)
        csr_pkg::ADDR_MEPC:    mepc    <= wdata;
        csr_pkg::ADDR_MCAUSE:  mcause  <= wdata;
        csr_pkg::ADDR_MTVEC:   mtvec   <= wdata;
        csr_pkg::ADDR_MSTATUS: mstatus <= wdata;
        default: ;   // write to nowhere
      endcase
    end
  end

  // sequencer read lands one cycle after the strobe
  always_ff @(posedge clk) begin
    if (i_ren) begin
      o_rdata <= read_csr(i_addr);
    end
  end

  always_comb begin
    o_host_rdata = read_csr(i_host_raddr);
  end

endmodule

// File: verilog/trap_sequencer.sv
// one trap event at a time, each csr access is strobe, capture, advance
// direct mtvec mode only, mret returns to U mode, no privilege checks
`timescale 1ns/1ps
`include "trap_settings.svh"

module trap_sequencer (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_evt_valid,
  input  trap_pkg::opcode_t  i_evt_opcode,
  input  trap_pkg::pc_t      i_evt_pc,
  output logic               o_evt_pop,
  output csr_pkg::csr_addr_t o_csr_addr,
  output logic               o_csr_ren,
  output logic               o_csr_wen,
  output csr_pkg::csr_data_t o_csr_wdata,
  input  csr_pkg::csr_data_t i_csr_rdata,
  output logic               o_redirect_valid,
  output trap_pkg::pc_t      o_redirect_pc,
  input  logic               i_redirect_ready
);

  // mstatus fields
  localparam int MIE    = 3;
  localparam int MPIE   = 7;
  localparam int MPP_LO = 11;
  localparam int MPP_HI = 12;

  trap_pkg::trap_state_e state;
  trap_pkg::trap_state_e access_next;
  logic [1:0]            step;

  csr_pkg::csr_data_t cause_q;
  csr_pkg::csr_data_t status_q;     // mstatus as read in this sequence
  csr_pkg::csr_data_t status_entry;
  csr_pkg::csr_data_t status_leave;
  trap_pkg::pc_t      pc_q;
  trap_pkg::pc_t      target_q;     // mtvec on entry, mepc on return

  logic is_read;
  logic is_write;

  assign o_evt_pop = (state == trap_pkg::IDLE) && i_evt_valid;

  always_comb begin
    status_entry                = status_q;
    status_entry[MPP_HI:MPP_LO] = 2'b11;
    status_entry[MPIE]          = status_q[MIE];
    status_entry[MIE]           = 1'b0;
    status_leave                = status_q;
    status_leave[MPP_HI:MPP_LO] = 2'b00;
    status_leave[MIE]           = status_q[MPIE];
    status_leave[MPIE]          = 1'b1;
  end

  // per-state access and the state that follows it
  always_comb begin
    o_csr_addr  = '0;
    o_csr_wdata = '0;
    is_read     = 1'b0;
    is_write    = 1'b0;
    access_next = trap_pkg::IDLE;
    case (state)
      trap_pkg::ENTER_WR_MEPC: begin
        o_csr_addr  = `CSR_ADDR_MEPC;
        o_csr_wdata = pc_q;
        is_write    = 1'b1;
        access_next = trap_pkg::ENTER_WR_MCAUSE;
      end
      trap_pkg::ENTER_WR_MCAUSE: begin
        o_csr_addr  = `CSR_ADDR_MCAUSE;
        o_csr_wdata = cause_q;
        is_write    = 1'b1;
        access_next = trap_pkg::ENTER_RD_MTVEC;
      end
      trap_pkg::ENTER_RD_MTVEC: begin
        o_csr_addr  = `CSR_ADDR_MTVEC;
        is_read     = 1'b1;
        access_next = trap_pkg::ENTER_RD_MSTATUS;
      end
      trap_pkg::ENTER_RD_MSTATUS: begin
        o_csr_addr  = `CSR_ADDR_MSTATUS;
        is_read     = 1'b1;
        access_next = trap_pkg::ENTER_WR_MSTATUS;
      end
      trap_pkg::ENTER_WR_MSTATUS: begin
        o_csr_addr  = `CSR_ADDR_MSTATUS;
        o_csr_wdata = status_entry;
        is_write    = 1'b1;
        access_next = trap_pkg::REDIRECT;
      end
      trap_pkg::LEAVE_RD_MSTATUS: begin
        o_csr_addr  = `CSR_ADDR_MSTATUS;
        is_read     = 1'b1;
        access_next = trap_pkg::LEAVE_RD_MEPC;
      end
      trap_pkg::LEAVE_RD_MEPC: begin
        o_csr_addr  = `CSR_ADDR_MEPC;
        is_read     = 1'b1;
        access_next = trap_pkg::LEAVE_WR_MSTATUS;
      end
      trap_pkg::LEAVE_WR_MSTATUS: begin
        o_csr_addr  = `CSR_ADDR_MSTATUS;
        o_csr_wdata = status_leave;
        is_write    = 1'b1;
        access_next = trap_pkg::REDIRECT;
      end
      default: ;
    endcase
  end

  assign o_csr_ren        = is_read && (step == 2'd0);    // strobe on first step only
  assign o_csr_wen        = is_write && (step == 2'd0);
  assign o_redirect_valid = (state == trap_pkg::REDIRECT);
  assign o_redirect_pc    = target_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= trap_pkg::IDLE;
      step  <= '0;
    end else begin
      case (state)
        trap_pkg::IDLE: begin
          step <= '0;
          if (i_evt_valid) begin
            state <= (i_evt_opcode == `TRAP_OP_MRET) ? trap_pkg::LEAVE_RD_MSTATUS
                                                     : trap_pkg::ENTER_WR_MEPC;
          end
        end
        trap_pkg::REDIRECT: begin
          if (i_redirect_ready) state <= trap_pkg::IDLE;   // hold until taken
        end
        default: begin
          if (step == 2'd2) begin
            state <= access_next;
            step  <= '0;
          end else begin
            step <= step + 2'd1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (o_evt_pop) begin
      pc_q    <= i_evt_pc;
      cause_q <= (i_evt_opcode == `TRAP_OP_ECALL) ? `TRAP_CAUSE_ECALL
                                                  : (`TRAP_CAUSE_TIMER);
    end
    // read data is valid in the step after the strobe
    if (is_read && step == 2'd1) begin
      if (o_csr_addr == `CSR_ADDR_MSTATUS) status_q <= i_csr_rdata;
      else                                 target_q <= i_csr_rdata;
    end
  end

endmodule

// File: verilog/trap_unit_top.sv
// trap path: event queue feeding the sequencer, which drives the csr file
// host port is meant for use while the sequencer is idle
`timescale 1ns/1ps

module trap_unit_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_evt_valid,
  output logic               o_evt_ready,
  input  trap_pkg::opcode_t  i_evt_opcode,
  input  trap_pkg::pc_t      i_evt_pc,
  output logic               o_redirect_valid,
  output trap_pkg::pc_t      o_redirect_pc,
  input  logic               i_redirect_ready,
  input  logic               i_host_wen,
  input  csr_pkg::csr_addr_t i_host_addr,
  input  csr_pkg::csr_data_t i_host_wdata,
  input  csr_pkg::csr_addr_t i_host_raddr,
  output csr_pkg::csr_data_t o_host_rdata
);

  logic               evt_valid;
  trap_pkg::opcode_t  evt_opcode;
  trap_pkg::pc_t      evt_pc;
  logic               evt_pop;
  csr_pkg::csr_addr_t csr_addr;
  logic               csr_ren;
  logic               csr_wen;
  csr_pkg::csr_data_t csr_wdata;
  csr_pkg::csr_data_t csr_rdata;

  trap_event_queue u_queue (
    .clk(clk), .rst(rst),
    .i_valid(i_evt_valid), .i_opcode(i_evt_opcode), .i_pc(i_evt_pc), .i_pop(evt_pop),
    .o_ready(o_evt_ready), .o_valid(evt_valid), .o_opcode(evt_opcode), .o_pc(evt_pc)
  );

  csr_file u_csr (
    .clk(clk), .rst(rst),
    .i_addr(csr_addr), .i_ren(csr_ren), .i_wen(csr_wen), .i_wdata(csr_wdata),
    .o_rdata(csr_rdata),
    .i_host_wen(i_host_wen), .i_host_addr(i_host_addr), .i_host_wdata(i_host_wdata),
    .i_host_raddr(i_host_raddr), .o_host_rdata(o_host_rdata)
  );

  trap_sequencer u_seq (
    .clk(clk), .rst(rst),
    .i_evt_valid(evt_valid), .i_evt_opcode(evt_opcode), .i_evt_pc(evt_pc),
    .o_evt_pop(evt_pop),
    .o_csr_addr(csr_addr), .o_csr_ren(csr_ren), .o_csr_wen(csr_wen),
    .o_csr_wdata(csr_wdata), .i_csr_rdata(csr_rdata),
    .o_redirect_valid(o_redirect_valid), .o_redirect_pc(o_redirect_pc),
    .i_redirect_ready(i_redirect_ready)
  );

endmodule

// File: test/trap_unit_assertions.sv
// concurrent checks on the event, csr and redirect handshakes of trap_unit_top
// all properties are disabled while rst is high
`timescale 1ns/1ps

module trap_unit_assertions (
  input logic          clk,
  input logic          rst,
  input logic          i_redirect_valid,
  input trap_pkg::pc_t i_redirect_pc,
  input logic          i_redirect_ready,
  input logic          i_csr_ren,
  input logic          i_csr_wen,
  input logic          i_evt_pop,
  input logic          i_evt_valid,
  input logic          i_evt_ready
);

  redirect_held: assert property (@(posedge clk) disable iff (rst)
    i_redirect_valid && !i_redirect_ready |=> i_redirect_valid && $stable(i_redirect_pc))
    else $error("redirect dropped or changed while not accepted");

  strobe_excl: assert property (@(posedge clk) disable iff (rst) !(i_csr_ren && i_csr_wen))
    else $error("csr read and write strobes high together");

  pop_valid: assert property (@(posedge clk) disable iff (rst) i_evt_pop |-> i_evt_valid)
    else $error("event popped from an empty queue");

  // full queue only drains through a pop
  full_no_accept: assert property (@(posedge clk) disable iff (rst)
    !i_evt_ready && !i_evt_pop |=> !i_evt_ready)
    else $error("queue changed while full with no pop");

endmodule

bind trap_unit_top trap_unit_assertions u_assertions (
  .clk(clk), .rst(rst),
  .i_redirect_valid(o_redirect_valid), .i_redirect_pc(o_redirect_pc),
  .i_redirect_ready(i_redirect_ready),
  .i_csr_ren(csr_ren), .i_csr_wen(csr_wen),
  .i_evt_pop(evt_pop), .i_evt_valid(evt_valid), .i_evt_ready(o_evt_ready)
);

// File: test/trap_unit_tb.sv
// random trap events checked against a model of the four csrs and redirect order
// host writes happen only while the sequencer is idle
`timescale 1ns/1ps
`include "trap_settings.svh"

module trap_unit_tb;

  localparam int CLK_PERIOD  = 4;
  localparam int BP_EVENTS   = `TRAP_QUEUE_DEPTH + 1;
  localparam int RAND_EVENTS = 60;
  localparam int N_EVENTS    = 3 + BP_EVENTS + RAND_EVENTS;
  localparam logic [63:0] CAUSE_ECALL = 64'd11;
  localparam logic [63:0] CAUSE_TIMER = 64'h8000_0000_0000_0007;

  logic               clk = 1'b0;
  logic               rst;
  logic               i_evt_valid;
  logic               o_evt_ready;
  trap_pkg::opcode_t  i_evt_opcode;
  trap_pkg::pc_t      i_evt_pc;
  logic               o_redirect_valid;
  trap_pkg::pc_t      o_redirect_pc;
  logic               i_redirect_ready;
  logic               i_host_wen;
  csr_pkg::csr_addr_t i_host_addr;
  csr_pkg::csr_data_t i_host_wdata;
  csr_pkg::csr_addr_t i_host_raddr;
  csr_pkg::csr_data_t o_host_rdata;

  logic [31:0]        lfsr       = 32'd69904;
  logic [31:0]        stall_lfsr = 32'd69904;
  logic               stall_bit;
  int                 stall_mode = 0;    // 0 ready, 1 held low, 2 random
  csr_pkg::csr_data_t m_mepc     = '0;
  csr_pkg::csr_data_t m_mcause   = '0;
  csr_pkg::csr_data_t m_mtvec    = '0;
  csr_pkg::csr_data_t m_mstatus  = '0;
  trap_pkg::pc_t      exp_q[$];
  int                 errors = 0;
  int                 checks = 0;
  int                 tests  = 0;
  int                 err_mark = 0;

  trap_unit_top UUT (
    .clk(clk), .rst(rst),
    .i_evt_valid(i_evt_valid), .o_evt_ready(o_evt_ready),
    .i_evt_opcode(i_evt_opcode), .i_evt_pc(i_evt_pc),
    .o_redirect_valid(o_redirect_valid), .o_redirect_pc(o_redirect_pc),
    .i_redirect_ready(i_redirect_ready),
    .i_host_wen(i_host_wen), .i_host_addr(i_host_addr), .i_host_wdata(i_host_wdata),
    .i_host_raddr(i_host_raddr), .o_host_rdata(o_host_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic trap_pkg::opcode_t pick_opcode();
    logic [1:0]        sel;
    trap_pkg::opcode_t op;
    sel = rand_bits(2);
    op  = rand_bits(8);
    if (op == `TRAP_OP_ECALL || op == `TRAP_OP_MRET) op = 8'hf0;   // keep it a timer
    if (sel == 2'd0) op = `TRAP_OP_ECALL;
    if (sel == 2'd1) op = `TRAP_OP_MRET;
    return op;
  endfunction

  function automatic logic [63:0] status_on_entry(input logic [63:0] s);
    logic [63:0] r;
    r        = s;
    r[12:11] = 2'b11;
    r[7]     = s[3];
    r[3]     = 1'b0;
    return r;
  endfunction

  function automatic logic [63:0] status_on_return(input logic [63:0] s);
    logic [63:0] r;
    r        = s;
    r[12:11] = 2'b00;
    r[3]     = s[7];
    r[7]     = 1'b1;
    return r;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_csr(input string name, input csr_pkg::csr_addr_t addr,
                           input logic [63:0] exp);
    @(negedge clk);
    i_host_raddr = addr;
    #1;
    check_val(name, o_host_rdata, exp);
  endtask

  task automatic check_all_csrs();
    check_csr("mepc", `CSR_ADDR_MEPC, m_mepc);
    check_csr("mcause", `CSR_ADDR_MCAUSE, m_mcause);
    check_csr("mtvec", `CSR_ADDR_MTVEC, m_mtvec);
    check_csr("mstatus", `CSR_ADDR_MSTATUS, m_mstatus);
  endtask

  task automatic host_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data);
    @(negedge clk);
    i_host_wen   = 1'b1;
    i_host_addr  = addr;
    i_host_wdata = data;
    @(negedge clk);
    i_host_wen = 1'b0;
    if (addr == `CSR_ADDR_MTVEC) m_mtvec = data;
    if (addr == `CSR_ADDR_MSTATUS) m_mstatus = data;
  endtask

  // model runs at accept time, events are served in order
  task automatic apply_model(input trap_pkg::opcode_t op, input trap_pkg::pc_t pc);
    if (op == `TRAP_OP_MRET) begin
      exp_q.push_back(m_mepc);
      m_mstatus = status_on_return(m_mstatus);
    end else begin
      m_mepc   = pc;
      m_mcause = (op == `TRAP_OP_ECALL) ? CAUSE_ECALL : CAUSE_TIMER;
      exp_q.push_back(m_mtvec);
      m_mstatus = status_on_entry(m_mstatus);
    end
  endtask

  task automatic send_event(input trap_pkg::opcode_t op, input trap_pkg::pc_t pc);
    @(negedge clk);
    i_evt_valid  = 1'b1;
    i_evt_opcode = op;
    i_evt_pc     = pc;
    do @(posedge clk); while (!o_evt_ready);
    apply_model(op, pc);
    @(negedge clk);
    i_evt_valid = 1'b0;
  endtask

  task automatic send_random();
    trap_pkg::opcode_t op;
    trap_pkg::pc_t     pc;
    op = pick_opcode();
    pc = rand_bits(64) & ~64'h3;
    send_event(op, pc);
  endtask

  task automatic set_stall(input int mode);
    @(negedge clk);
    #1;
    stall_mode = mode;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
    err_mark = errors;
  endtask

  always @(negedge clk) begin
    if (stall_mode == 2) begin
      stall_lfsr       = lfsr_next(stall_lfsr);
      stall_bit        = stall_lfsr[0];
      stall_lfsr       = lfsr_next(stall_lfsr);
      i_redirect_ready = stall_bit | stall_lfsr[0];   // ready 3 of 4 cycles
    end else begin
      i_redirect_ready = (stall_mode == 0);
    end
  end

  // redirect monitor, compares against the model in arrival order
  always @(posedge clk) begin
    if (!rst && o_redirect_valid) begin
      assert (exp_q.size() != 0) else begin
        $display("ERROR %0t redirect raised with no event outstanding", $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        check_val("o_redirect_pc", o_redirect_pc, exp_q[0]);
        if (i_redirect_ready) begin
          void'(exp_q.pop_front());
        end
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (N_EVENTS * 40 + 300));
    $display("watchdog expired with %0d redirects still outstanding", exp_q.size());
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    rst              = 1'b1;
    i_evt_valid      = 1'b0;
    i_evt_opcode     = '0;
    i_evt_pc         = '0;
    i_redirect_ready = 1'b1;
    i_host_wen       = 1'b0;
    i_host_addr      = '0;
    i_host_wdata     = '0;
    i_host_raddr     = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_val("o_redirect_valid", o_redirect_valid, 1'b0);
    check_val("o_evt_ready", o_evt_ready, 1'b1);
    check_all_csrs();
    end_test("reset");

    host_write(`CSR_ADDR_MTVEC, rand_bits(64) & ~64'h3);
    host_write(`CSR_ADDR_MSTATUS, rand_bits(64) | 64'h8);   // MIE set going in
    send_event(`TRAP_OP_ECALL, rand_bits(64) & ~64'h3);
    wait_idle();
    check_csr("mcause", `CSR_ADDR_MCAUSE, CAUSE_ECALL);
    check_all_csrs();
    end_test("ecall entry");

    send_event(8'h47, rand_bits(64) & ~64'h3);
    wait_idle();
    check_csr("mcause", `CSR_ADDR_MCAUSE, CAUSE_TIMER);
    check_all_csrs();
    end_test("timer entry");

    send_event(`TRAP_OP_MRET, '0);
    wait_idle();
    check_all_csrs();
    end_test("mret return");

    set_stall(1);
    repeat (BP_EVENTS) send_random();
    @(negedge clk);
    check_val("o_evt_ready", o_evt_ready, 1'b0);
    while (!o_redirect_valid) @(negedge clk);
    repeat (4) @(negedge clk);
    check_val("o_redirect_pc", o_redirect_pc, exp_q[0]);
    set_stall(0);
    wait_idle();
    check_all_csrs();
    end_test("back-pressure");

    set_stall(2);
    repeat (RAND_EVENTS) begin
      send_random();
      repeat (rand_bits(2)) @(negedge clk);
    end
    wait_idle();
    check_all_csrs();
    check_val("o_redirect_valid", o_redirect_valid, 1'b0);
    end_test("random run");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: trap_unit_top.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/trap_pkg.sv
verilog/trap_event_queue.sv
verilog/csr_file.sv
verilog/trap_sequencer.sv
verilog/trap_unit_top.sv
test/trap_unit_assertions.sv
test/trap_unit_tb.sv
